/* src/afifo_cfg_pkg.sv */
/*
 * Dual-clock FIFO configuration
 * Sizes shared by every block: address and data width, depth,
 * synchronizer length and the data word carried through the FIFO
 */
package afifo_cfg_pkg;

	////////////////////////////////////////////////////////////
	// Storage geometry
	////////////////////////////////////////////////////////////

	// Log2 of the number of entries
	localparam int AW = 3;

	// Number of entries
	localparam int DEPTH = 1 << AW;

	// Bits per stored word
	localparam int DW = 16;

	// Flops per clock domain crossing, two is the minimum
	localparam int NFF = 2;

	// One word as it enters and leaves the FIFO
	typedef logic [DW-1:0] data_t;

endpackage

/* src/afifo_ptr_pkg.sv */
/*
 * Dual-clock FIFO pointer types
 * Binary pointer with its two views and the Gray code
 * used to pass a pointer into the other clock domain
 */
package afifo_ptr_pkg;

	import afifo_cfg_pkg::*;

	// Binary pointer, one bit wider than the address
	// Raw view is counted and compared, field view addresses the array
	typedef union packed {
		logic [AW:0] raw;
		struct packed {
			// Toggles once per pass through the array
			logic          wrap;
			logic [AW-1:0] idx;
		} f;
	} ptr_t;

	// Gray-coded pointer, only one bit changes per step
	typedef logic [AW:0] gray_t;

	// Binary to Gray
	function automatic gray_t to_gray(input ptr_t p);
		return p.raw ^ (p.raw >> 1);
	endfunction

endpackage

/* src/afifo_mem_if.sv */
/*
 * FIFO storage bus
 * Joins the write controller, the read controller and the array
 */
`timescale 1ns/1ps

interface afifo_mem_if import afifo_cfg_pkg::*; ();

	// Write side, one strobe per accepted word
	logic          wr_en;
	logic [AW-1:0] wr_addr;
	data_t         wr_data;

	// Read side, data follows the address with no latency
	logic [AW-1:0] rd_addr;
	data_t         rd_data;

	// Write controller
	modport wr (output wr_en, output wr_addr, output wr_data);

	// Read controller
	modport rd (output rd_addr, input rd_data);

	// Storage array
	modport mem (
		input  wr_en,
		input  wr_addr,
		input  wr_data,
		input  rd_addr,
		output rd_data
	);

endinterface

/* src/afifo_mem.sv */
/*
 * FIFO storage array
 * Written on the write clock, read asynchronously by address
 */
`timescale 1ns/1ps

module afifo_mem import afifo_cfg_pkg::*; (
	// Write clock
	input  logic      i_wclk,
	// Storage bus
	afifo_mem_if.mem  mem_bus
);

	// DEPTH words, no reset on the contents
	data_t mem_arr [DEPTH];

	////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////

	// One word per strobe
	always_ff @(posedge i_wclk)
	begin
		if (mem_bus.wr_en)
			mem_arr[mem_bus.wr_addr] <= mem_bus.wr_data;
	end

	////////////////////////////////////////////////////////////
	// Read port
	////////////////////////////////////////////////////////////

	// Combinational read, the read controller registers the word
	assign mem_bus.rd_data = mem_arr[mem_bus.rd_addr];

endmodule

/* src/afifo_wr_ctrl.sv */
/*
 * FIFO write controller
 * Keeps the write pointer and its Gray copy, brings the read
 * pointer across from the read domain and raises the full flag
 */
`timescale 1ns/1ps

module afifo_wr_ctrl import afifo_cfg_pkg::*; import afifo_ptr_pkg::*; (
	// Write clock and reset
	input  logic     i_wclk,
	input  logic     i_wr_reset_n,
	// Write request
	input  logic     i_wr,
	input  data_t    i_wr_data,
	output logic     o_wr_full,
	// Gray pointers crossing between the domains
	input  gray_t    i_rd_gray,
	output gray_t    o_wr_gray,
	// Storage bus
	afifo_mem_if.wr  mem_bus
);

	ptr_t             wr_ptr;
	ptr_t             wr_ptr_nxt;
	gray_t            wr_gray;
	gray_t [NFF-1:0]  rd_sync;
	logic             wr_accept;

	////////////////////////////////////////////////////////////
	// Write pointer
	////////////////////////////////////////////////////////////

	// Ignored while full
	assign wr_accept = i_wr && !o_wr_full;

	always_comb
	begin
		wr_ptr_nxt.raw = wr_ptr.raw + (AW+1)'(1);
	end

	// Binary and Gray advance together on each accepted word
	always_ff @(posedge i_wclk or negedge i_wr_reset_n)
	begin
		if (!i_wr_reset_n)
		begin
			wr_ptr  <= '0;
			wr_gray <= '0;
		end
		else if (wr_accept)
		begin
			wr_ptr  <= wr_ptr_nxt;
			wr_gray <= to_gray(wr_ptr_nxt);
		end
	end

	// Index field addresses the array
	assign mem_bus.wr_en   = wr_accept;
	assign mem_bus.wr_addr = wr_ptr.f.idx;
	assign mem_bus.wr_data = i_wr_data;

	// Registered Gray copy goes to the read domain
	assign o_wr_gray = wr_gray;

	////////////////////////////////////////////////////////////
	// Read pointer synchronizer
	////////////////////////////////////////////////////////////

	// NFF stages with the oldest value in the top slot
	always_ff @(posedge i_wclk or negedge i_wr_reset_n)
	begin
		if (!i_wr_reset_n)
			rd_sync <= '0;
		else
			rd_sync <= {rd_sync[NFF-2:0], i_rd_gray};
	end

	// Full when the write pointer is one lap ahead of the read pointer
	// In Gray code that means the top two bits differ and the rest match
	assign o_wr_full = (rd_sync[NFF-1] == {~wr_gray[AW:AW-1], wr_gray[AW-2:0]});

endmodule

/* src/afifo_rd_ctrl.sv */
/*
 * FIFO read controller
 * Keeps the read pointer, brings the write pointer across from
 * the write domain and holds the front word in an output register
 */
`timescale 1ns/1ps

module afifo_rd_ctrl import afifo_cfg_pkg::*; import afifo_ptr_pkg::*; (
	// Read clock and reset
	input  logic     gbl_clk,
	input  logic     i_rd_reset_n,
	// Read request
	input  logic     i_rd,
	// Gray pointers crossing between the domains
	input  gray_t    i_wr_gray,
	output gray_t    o_rd_gray,
	// Registered output word
	output data_t    o_rd_data,
	output logic     o_rd_empty,
	// Storage bus
	afifo_mem_if.rd  mem_bus
);

	ptr_t             rd_ptr;
	ptr_t             rd_ptr_nxt;
	gray_t            rd_gray;
	gray_t [NFF-1:0]  wr_sync;
	logic             lcl_empty;
	logic             lcl_read;
	logic             rd_take;

	////////////////////////////////////////////////////////////
	// Write pointer synchronizer
	////////////////////////////////////////////////////////////

	// NFF stages with the oldest value in the top slot
	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
	begin
		if (!i_rd_reset_n)
			wr_sync <= '0;
		else
			wr_sync <= {wr_sync[NFF-2:0], i_wr_gray};
	end

	// Nothing stored beyond what the output already holds
	assign lcl_empty = (wr_sync[NFF-1] == rd_gray);

	////////////////////////////////////////////////////////////
	// Read pointer
	////////////////////////////////////////////////////////////

	// Output slot is free or its word is being consumed
	assign lcl_read = o_rd_empty || i_rd;

	// Load moves a real word out of the array
	assign rd_take = lcl_read && !lcl_empty;

	always_comb
	begin
		rd_ptr_nxt.raw = rd_ptr.raw + (AW+1)'(1);
	end

	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
	begin
		if (!i_rd_reset_n)
		begin
			rd_ptr  <= '0;
			rd_gray <= '0;
		end
		else if (rd_take)
		begin
			rd_ptr  <= rd_ptr_nxt;
			rd_gray <= to_gray(rd_ptr_nxt);
		end
	end

	// Array is read at the current front index
	assign mem_bus.rd_addr = rd_ptr.f.idx;

	// Goes back to the write domain for the full flag
	assign o_rd_gray = rd_gray;

	////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////

	// Empty follows the internal flag whenever the slot reloads
	// and holds under back-pressure
	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
	begin
		if (!i_rd_reset_n)
			o_rd_empty <= 1'b1;
		else if (lcl_read)
			o_rd_empty <= lcl_empty;
	end

	// Payload is only replaced by a real word
	always_ff @(posedge gbl_clk)
	begin
		if (rd_take)
			o_rd_data <= mem_bus.rd_data;
	end

endmodule

/* src/afifo_top.sv */
/*
 * Dual-clock FIFO
 * Carries data words from the write clock domain into gbl_clk,
 * first-word-fall-through with a registered read side
 */
`timescale 1ns/1ps

module afifo_top import afifo_cfg_pkg::*; import afifo_ptr_pkg::*; (
	// Write domain
	input  logic   i_wclk,
	input  logic   i_wr_reset_n,
	input  logic   i_wr,
	input  data_t  i_wr_data,
	output logic   o_wr_full,
	// Read domain
	input  logic   gbl_clk,
	input  logic   i_rd_reset_n,
	input  logic   i_rd,
	output data_t  o_rd_data,
	output logic   o_rd_empty
);

	// Gray pointers between the two controllers
	gray_t wr_gray;
	gray_t rd_gray;

	////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////

	afifo_mem_if mem_bus ();

	afifo_mem u_mem (
		.i_wclk  (i_wclk),
		.mem_bus (mem_bus.mem)
	);

	////////////////////////////////////////////////////////////
	// Controllers
	////////////////////////////////////////////////////////////

	// Write domain
	afifo_wr_ctrl u_wr_ctrl (
		.i_wclk       (i_wclk),
		.i_wr_reset_n (i_wr_reset_n),
		.i_wr         (i_wr),
		.i_wr_data    (i_wr_data),
		.o_wr_full    (o_wr_full),
		.i_rd_gray    (rd_gray),
		.o_wr_gray    (wr_gray),
		.mem_bus      (mem_bus.wr)
	);

	// Read domain
	afifo_rd_ctrl u_rd_ctrl (
		.gbl_clk      (gbl_clk),
		.i_rd_reset_n (i_rd_reset_n),
		.i_rd         (i_rd),
		.i_wr_gray    (wr_gray),
		.o_rd_gray    (rd_gray),
		.o_rd_data    (o_rd_data),
		.o_rd_empty   (o_rd_empty),
		.mem_bus      (mem_bus.rd)
	);

endmodule

/* sim/afifo_chk.sv */
/*
 * Dual-clock FIFO checker
 * Bound into the FIFO top level, watches the reset state,
 * read-side hold under back-pressure and the words in flight
 */
`timescale 1ns/1ps

module afifo_chk import afifo_cfg_pkg::*; (
	input logic   i_wclk,
	input logic   i_wr_reset_n,
	input logic   i_wr,
	input logic   o_wr_full,
	input logic   gbl_clk,
	input logic   i_rd_reset_n,
	input logic   i_rd,
	input data_t  o_rd_data,
	input logic   o_rd_empty
);

	// Accepted writes and completed reads, each in its own domain
	int wr_count;
	int rd_count;
	// One failure count per assertion
	int rd_rst_fails = 0;
	int wr_rst_fails = 0;
	int hold_fails = 0;
	int fill_fails = 0;
	int fail_total;

	assign fail_total = rd_rst_fails + wr_rst_fails + hold_fails + fill_fails;

	always_ff @(posedge i_wclk or negedge i_wr_reset_n)
	begin
		if (!i_wr_reset_n)
			wr_count <= 0;
		else if (i_wr && !o_wr_full)
			wr_count <= wr_count + 1;
	end

	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
	begin
		if (!i_rd_reset_n)
			rd_count <= 0;
		else if (i_rd && !o_rd_empty)
			rd_count <= rd_count + 1;
	end

	////////////////////////////////////////////////////////////
	// Reset state
	////////////////////////////////////////////////////////////

	a_rd_rst: assert property (@(posedge gbl_clk) !i_rd_reset_n |-> o_rd_empty)
	else
	begin
		rd_rst_fails++;
		$error("o_rd_empty is low while the read reset is asserted");
	end

	a_wr_rst: assert property (@(posedge i_wclk) !i_wr_reset_n |-> !o_wr_full)
	else
	begin
		wr_rst_fails++;
		$error("o_wr_full is high while the write reset is asserted");
	end

	////////////////////////////////////////////////////////////
	// Read side and occupancy
	////////////////////////////////////////////////////////////

	// Front word and flag hold while the reader stalls
	a_hold: assert property (@(posedge gbl_clk) disable iff (!i_rd_reset_n)
		(!o_rd_empty && !i_rd) |=> ($stable(o_rd_data) && $stable(o_rd_empty)))
	else
	begin
		hold_fails++;
		$error("Output word or empty flag changed while the reader stalled");
	end

	// Array entries plus the word held in the output register
	a_fill: assert property (@(posedge i_wclk) disable iff (!i_wr_reset_n)
		(wr_count - rd_count) <= DEPTH + 1)
	else
	begin
		fill_fails++;
		$error("More words accepted than the FIFO can hold");
	end

endmodule

bind afifo_top afifo_chk u_chk (
	.i_wclk       (i_wclk),
	.i_wr_reset_n (i_wr_reset_n),
	.i_wr         (i_wr),
	.o_wr_full    (o_wr_full),
	.gbl_clk      (gbl_clk),
	.i_rd_reset_n (i_rd_reset_n),
	.i_rd         (i_rd),
	.o_rd_data    (o_rd_data),
	.o_rd_empty   (o_rd_empty)
);

/* sim/afifo_tb.sv */
/*
 * Dual-clock FIFO testbench
 * Fills the FIFO, drains it, then runs random traffic on both
 * clocks and checks every word read against a reference queue
 */
`timescale 1ns/1ps

module afifo_tb import afifo_cfg_pkg::*; ();

	localparam int CLK_NS = 20;
	localparam int WCLK_NS = 14;
	localparam int FULL_PUSHES = 8;
	localparam int MIX_RD = 300;
	localparam int MIX_WR = MIX_RD * CLK_NS / WCLK_NS;
	// Watchdog limit from the length of each phase
	localparam int RESET_NS = 12 * CLK_NS;
	localparam int FILL_NS = (4 * DEPTH + FULL_PUSHES + 4) * WCLK_NS;
	localparam int DRAIN_NS = (2 * DEPTH + 4 * NFF + 8) * CLK_NS;
	localparam int MIX_NS = (MIX_RD + 1) * CLK_NS;
	localparam int TIMEOUT_NS = RESET_NS + FILL_NS + 2 * DRAIN_NS + MIX_NS + 1000;

	logic  gbl_clk;
	logic  i_wclk;
	logic  i_rd_reset_n;
	logic  i_wr_reset_n;
	logic  i_wr;
	logic  i_rd;
	data_t i_wr_data;
	data_t o_rd_data;
	logic  o_wr_full;
	logic  o_rd_empty;

	// Accepted words in order, the read side walks it by index
	data_t       ref_q[$];
	int          rd_idx = 0;
	int          idle_cycles = 0;
	bit          filling = 1'b0;
	int          wr_errors = 0;
	int          rd_errors = 0;
	int          seq_errors = 0;
	logic [31:0] wr_seed = 32'd81;
	logic [31:0] rd_seed;

	afifo_top UUT (
		.i_wclk       (i_wclk),
		.i_wr_reset_n (i_wr_reset_n),
		.i_wr         (i_wr),
		.i_wr_data    (i_wr_data),
		.o_wr_full    (o_wr_full),
		.gbl_clk      (gbl_clk),
		.i_rd_reset_n (i_rd_reset_n),
		.i_rd         (i_rd),
		.o_rd_data    (o_rd_data),
		.o_rd_empty   (o_rd_empty)
	);

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	initial
	begin
		gbl_clk = 1'b0;
		forever #(CLK_NS / 2) gbl_clk = ~gbl_clk;
	end

	initial
	begin
		i_wclk = 1'b0;
		forever #(WCLK_NS / 2) i_wclk = ~i_wclk;
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("Timeout: the test phases did not finish within %0d ns", TIMEOUT_NS);
		$display("Result: FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Monitors
	////////////////////////////////////////////////////////////

	// Record accepted writes, count while full during the fill
	always @(posedge i_wclk)
	begin
		if (i_wr_reset_n && i_wr && !o_wr_full)
			ref_q.push_back(i_wr_data);
		if (filling && o_wr_full)
		begin
			assert (ref_q.size() >= DEPTH && ref_q.size() <= DEPTH + 1)
			else
			begin
				$display("CHECK FAILED at %0t: o_wr_full words stored expected %0d, got %0d",
					$time, DEPTH, ref_q.size());
				wr_errors++;
			end
		end
	end

	// Compare each consumed word with the oldest unread write
	always @(posedge gbl_clk)
	begin
		if (i_rd_reset_n)
		begin
			if (ref_q.size() == rd_idx)
				idle_cycles = idle_cycles + 1;
			else
				idle_cycles = 0;
			if (idle_cycles > NFF + 3)
			begin
				assert (o_rd_empty)
				else
				begin
					$display("CHECK FAILED at %0t: o_rd_empty expected 1, got %b",
						$time, o_rd_empty);
					rd_errors++;
				end
			end
			if (i_rd && !o_rd_empty)
			begin
				assert (rd_idx < ref_q.size())
				else
				begin
					$display("Read at %0t presented data with no word outstanding", $time);
					rd_errors++;
				end
				if (rd_idx < ref_q.size())
				begin
					assert (o_rd_data == ref_q[rd_idx])
					else
					begin
						$display("CHECK FAILED at %0t: o_rd_data expected %h, got %h",
							$time, ref_q[rd_idx], o_rd_data);
						rd_errors++;
					end
					rd_idx++;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	// Write until full, then keep pushing against the full flag
	task automatic fill_until_full();
		bit seen_full;
		begin
			seen_full = 1'b0;
			while (!seen_full)
			begin
				@(posedge i_wclk);
				seen_full = o_wr_full;
				wr_seed = lcg(wr_seed);
				i_wr      <= 1'b1;
				i_wr_data <= wr_seed[31:16];
			end
			repeat (FULL_PUSHES)
			begin
				@(posedge i_wclk);
				wr_seed = lcg(wr_seed);
				i_wr_data <= wr_seed[31:16];
			end
			@(posedge i_wclk);
			i_wr <= 1'b0;
		end
	endtask

	// Read until the empty flag has settled high
	task automatic drain_fifo();
		int empty_run;
		begin
			empty_run = 0;
			while (empty_run < NFF + 4)
			begin
				@(posedge gbl_clk);
				if (o_rd_empty)
					empty_run++;
				else
					empty_run = 0;
				i_rd <= 1'b1;
			end
			i_rd <= 1'b0;
		end
	endtask

	initial
	begin
		i_rd_reset_n = 1'b1;
		i_wr_reset_n = 1'b1;
		i_wr         = 1'b0;
		i_rd         = 1'b0;
		i_wr_data    = '0;
		rd_seed      = lcg(32'd81);
		@(posedge gbl_clk);
		i_rd_reset_n <= 1'b0;
		i_wr_reset_n <= 1'b0;
		repeat (10) @(posedge gbl_clk);
		i_rd_reset_n <= 1'b1;
		i_wr_reset_n <= 1'b1;
		filling = 1'b1;
		fill_until_full();
		@(posedge gbl_clk);
		filling = 1'b0;
		drain_fifo();
		// Random traffic on both clocks
		fork
			begin
				repeat (MIX_WR)
				begin
					@(posedge i_wclk);
					wr_seed = lcg(wr_seed);
					i_wr      <= wr_seed[20] | wr_seed[9];
					i_wr_data <= wr_seed[31:16];
				end
				@(posedge i_wclk);
				i_wr <= 1'b0;
			end
			begin
				repeat (MIX_RD)
				begin
					@(posedge gbl_clk);
					rd_seed = lcg(rd_seed);
					i_rd <= rd_seed[27];
				end
			end
		join
		drain_fifo();
		@(posedge gbl_clk);
		assert (ref_q.size() == rd_idx)
		else
		begin
			$display("CHECK FAILED at %0t: words outstanding expected 0, got %0d",
				$time, ref_q.size() - rd_idx);
			seq_errors++;
		end
		$display("Errors: %0d testbench, %0d assertion",
			wr_errors + rd_errors + seq_errors, UUT.u_chk.fail_total);
		if (wr_errors + rd_errors + seq_errors + UUT.u_chk.fail_total == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* sources.f */
src/afifo_cfg_pkg.sv
src/afifo_ptr_pkg.sv
src/afifo_mem_if.sv
src/afifo_mem.sv
src/afifo_wr_ctrl.sv
src/afifo_rd_ctrl.sv
src/afifo_top.sv
sim/afifo_chk.sv
sim/afifo_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the dual-clock FIFO testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module afifo_tb -Mdir obj_dir -f sources.f

# The log decides the result, so the run status is not used here
./obj_dir/Vafifo_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi

if ! grep -q "Result: PASSED" sim.log; then
	echo "Simulation ended without a result line"
	exit 1
fi

echo "Simulation finished cleanly"
